//--- files.f
hw/apu_cfg_pkg.sv
hw/apu_op_pkg.sv
hw/apu_arbiter.sv
hw/int_mult_unit.sv
hw/int_div_unit.sv
hw/core_return_merge.sv
hw/apu_cluster.sv
testbench/apu_arbiter_assert.sv
testbench/apu_cluster_tb.sv

//--- run.sh
#!/bin/sh
# Build the cluster testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module apu_cluster_tb -f files.f -o apu_cluster_sim

# A stopped run still leaves its log for the search below
./obj_dir/apu_cluster_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- testbench/apu_cluster_tb.sv
// Cluster testbench: clock, reset, random core requests, reference model, result checks, timeout
`default_nettype none

module apu_cluster_tb;

   import apu_cfg_pkg::*;
   import apu_op_pkg::*;

   localparam int NB_CORES    = 4;
   localparam int MULT_STAGES = 2;
   localparam int DIV_LATENCY = DATA_WIDTH + 2;
   localparam int NB_RESULTS  = 160;
   // 160 requests at up to 4 x 36 cycles each, plus margin
   localparam int MAX_CYCLES  = 25000;

   logic      clk;
   logic      rst_n;
   logic      req    [NB_CORES];
   apu_type_t typ    [NB_CORES];
   op_t       op     [NB_CORES];
   data_t     opa    [NB_CORES];
   data_t     opb    [NB_CORES];
   data_t     opc    [NB_CORES];
   logic      ack    [NB_CORES];
   logic      rvalid [NB_CORES];
   data_t     result [NB_CORES];

   integer seed = 16;

   apu_cluster #(
      .NB_CORES    (NB_CORES),
      .MULT_STAGES (MULT_STAGES)
   ) UUT (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .req_i          (req),
      .type_i         (typ),
      .op_i           (op),
      .operand_a_i    (opa),
      .operand_b_i    (opb),
      .operand_c_i    (opc),
      .ack_o          (ack),
      .result_valid_o (rvalid),
      .result_o       (result)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic data_t mult_model(op_t o, data_t a, data_t b, data_t c);
      longint          sp;
      longint unsigned up;
      sp = longint'($signed(a)) * longint'($signed(b));
      up = {32'd0, a} * {32'd0, b};
      case (o)
         OP_MUL:   return up[31:0];
         OP_MULH:  return sp[63:32];
         OP_MULHU: return up[63:32];
         default:  return data_t'(up[31:0] + c);
      endcase
   endfunction

   function automatic data_t div_model(op_t o, data_t a, data_t b);
      logic is_rem;
      is_rem = (o == OP_REM) || (o == OP_REMU);
      // Zero divisor and signed overflow
      if (b == '0) return is_rem ? a : '1;
      if ((o == OP_DIV || o == OP_REM) && a == 32'h8000_0000 && b == '1) return is_rem ? '0 : a;
      case (o)
         OP_DIV:  return $signed(a) / $signed(b);
         OP_DIVU: return a / b;
         OP_REM:  return $signed(a) % $signed(b);
         default: return a % b;
      endcase
   endfunction

   function automatic string op_name(apu_type_t t, op_t o);
      mult_op_t mo;
      div_op_t  dop;
      mo  = mult_op_t'(o);
      dop = div_op_t'(o);
      return (t == APU_MULT) ? mo.name() : dop.name();
   endfunction

   // Corner values in three picks out of eight
   function automatic data_t pick_operand();
      int sel;
      sel = $random(seed) & 7;
      case (sel)
         0:       return '0;
         1:       return '1;
         2:       return 32'h8000_0000;
         default: return $random(seed);
      endcase
   endfunction

   function automatic int assert_fails();
      return UUT.u_mult_arb.u_arb_chk.onehot_fails + UUT.u_mult_arb.u_arb_chk.grant_fails
           + UUT.u_mult_arb.u_arb_chk.valid_fails + UUT.u_div_arb.u_arb_chk.onehot_fails
           + UUT.u_div_arb.u_arb_chk.grant_fails + UUT.u_div_arb.u_arb_chk.valid_fails;
   endfunction

   task automatic report_failure(input string line);
      $display("%s", line);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   //////////////////////////////
   // Stimulus and scoreboard
   //////////////////////////////

   initial begin : stimulus
      logic      outstanding [NB_CORES];
      apu_type_t out_type    [NB_CORES];
      data_t     exp_val     [NB_CORES];
      int        ack_cycle   [NB_CORES];
      int        wait_grants [NB_CORES];
      string     tname       [NB_CORES];
      logic      div_busy;
      logic      mult_pending;
      logic      mult_acked;
      int        cycle;
      int        checked;
      int        issued;
      int        latency;
      int        r;
      apu_type_t t;
      op_t       o;
      data_t     a;
      data_t     b;
      data_t     c;
      div_busy = 1'b0;
      cycle    = 0;
      checked  = 0;
      issued   = 0;
      for (int i = 0; i < NB_CORES; i++) begin
         req[i] <= 1'b0;
         typ[i] <= APU_MULT;
         op[i]  <= '0;
         opa[i] <= '0;
         opb[i] <= '0;
         opc[i] <= '0;
         outstanding[i] = 1'b0;
         wait_grants[i] = 0;
      end
      rst_n <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      while (checked < NB_RESULTS) begin
         @(posedge clk);
         cycle++;
         if (cycle > MAX_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles, %0d results checked",
                                     cycle, checked));
         end
         if (assert_fails() != 0) begin
            report_failure("arbiter assertion failed");
         end
         // Results first, a finished division frees the divider at this edge
         for (int i = 0; i < NB_CORES; i++) begin
            if (rvalid[i]) begin
               assert (outstanding[i])
                  else report_failure($sformatf("result at core %0d with nothing outstanding", i));
               latency = (out_type[i] == APU_MULT) ? MULT_STAGES : DIV_LATENCY;
               assert (cycle - ack_cycle[i] == latency)
                  else report_failure($sformatf("mismatch %s latency expected %0d actual %0d",
                                                tname[i], latency, cycle - ack_cycle[i]));
               assert (result[i] == exp_val[i])
                  else report_failure($sformatf("mismatch %s expected %h actual %h",
                                                tname[i], exp_val[i], result[i]));
               if (out_type[i] == APU_DIV) div_busy = 1'b0;
               outstanding[i] = 1'b0;
               checked++;
            end
         end
         // Waiting multiplier requests get an ack every cycle
         mult_pending = 1'b0;
         mult_acked   = 1'b0;
         for (int i = 0; i < NB_CORES; i++) begin
            if (req[i] && typ[i] == APU_MULT) mult_pending = 1'b1;
            if (ack[i] && typ[i] == APU_MULT) mult_acked = 1'b1;
         end
         assert (!mult_pending || mult_acked)
            else report_failure("multiplier request waiting without a multiplier ack");
         for (int i = 0; i < NB_CORES; i++) begin
            if (ack[i]) begin
               if (typ[i] == APU_DIV) begin
                  assert (!div_busy)
                     else report_failure("divider ack while a division is still running");
                  div_busy = 1'b1;
               end
               assert (wait_grants[i] < NB_CORES)
                  else report_failure($sformatf("core %0d waited %0d grants for its ack",
                                                i, wait_grants[i]));
               req[i] <= 1'b0;
               outstanding[i] = 1'b1;
               out_type[i]    = typ[i];
               ack_cycle[i]   = cycle;
            end
         end
         // Grants to other cores of the same type while a core waits
         for (int i = 0; i < NB_CORES; i++) begin
            for (int j = 0; j < NB_CORES; j++) begin
               if (req[i] && !ack[i] && ack[j] && typ[j] == typ[i]) wait_grants[i]++;
            end
         end
         for (int i = 0; i < NB_CORES; i++) begin
            if (!outstanding[i] && !req[i] && ($random(seed) & 3) == 0) begin
               r = $random(seed);
               t = r[0] ? APU_DIV : APU_MULT;
               o = op_t'(r[2:1]);
               a = pick_operand();
               b = pick_operand();
               c = pick_operand();
               // Every 16th request divides the most negative number by minus one
               if (issued % 16 == 0) begin
                  t = APU_DIV;
                  o = r[2] ? OP_REM : OP_DIV;
                  a = 32'h8000_0000;
                  b = '1;
               end
               issued++;
               req[i] <= 1'b1;
               typ[i] <= t;
               op[i]  <= o;
               opa[i] <= a;
               opb[i] <= b;
               opc[i] <= c;
               exp_val[i]     = (t == APU_MULT) ? mult_model(o, a, b, c) : div_model(o, a, b);
               tname[i]       = $sformatf("%s core %0d", op_name(t, o), i);
               wait_grants[i] = 0;
            end
         end
      end

      // Assertions on the last edge report after it
      @(negedge clk);
      if (assert_fails() != 0) begin
         report_failure("arbiter assertion failed");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- testbench/apu_arbiter_assert.sv
// Concurrent checks on arbiter grants, bound to every apu_arbiter instance
`default_nettype none

module apu_arbiter_assert #(
   parameter int                     NB_CORES = apu_cfg_pkg::DEF_NB_CORES,
   parameter apu_cfg_pkg::apu_type_t APU_TYPE = apu_cfg_pkg::APU_MULT
) (
   input logic                   clk_i,
   input logic                   rst_n_i,
   input logic                   req_i  [NB_CORES],
   input apu_cfg_pkg::apu_type_t type_i [NB_CORES],
   input logic                   ack_i  [NB_CORES],
   input logic                   unit_valid_i
);

   import apu_cfg_pkg::*;

   logic [NB_CORES-1:0] ack_vec;
   logic                stray_ack;

   // Failure counts per property
   int onehot_fails = 0;
   int grant_fails  = 0;
   int valid_fails  = 0;

   // Ack without a matching request of this type
   always_comb begin
      stray_ack = 1'b0;
      for (int i = 0; i < NB_CORES; i++) begin
         ack_vec[i] = ack_i[i];
         if (ack_i[i] && !(req_i[i] && type_i[i] == APU_TYPE)) stray_ack = 1'b1;
      end
   end

   ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(ack_vec))
      else begin onehot_fails++; $error("more than one core acked at once"); end

   ack_matches_req: assert property (@(posedge clk_i) disable iff (!rst_n_i) !stray_ack)
      else begin grant_fails++; $error("ack given to a core without a matching request"); end

   valid_has_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                   unit_valid_i |-> (ack_vec != '0))
      else begin valid_fails++; $error("unit valid raised without any core ack"); end

endmodule

bind apu_arbiter apu_arbiter_assert #(
   .NB_CORES (NB_CORES),
   .APU_TYPE (APU_TYPE)
) u_arb_chk (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .req_i        (req_i),
   .type_i       (type_i),
   .ack_i        (ack_o),
   .unit_valid_i (unit_valid_o)
);

`default_nettype wire

//--- hw/apu_cluster.sv
// Shared arithmetic cluster top: request packing, two arbiters, multiplier, divider, merge
`default_nettype none

module apu_cluster #(
   parameter int NB_CORES    = apu_cfg_pkg::DEF_NB_CORES,
   parameter int MULT_STAGES = apu_cfg_pkg::DEF_MULT_STAGES
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   input  logic                   req_i          [NB_CORES],
   input  apu_cfg_pkg::apu_type_t type_i         [NB_CORES],
   input  apu_op_pkg::op_t        op_i           [NB_CORES],
   input  apu_cfg_pkg::data_t     operand_a_i    [NB_CORES],
   input  apu_cfg_pkg::data_t     operand_b_i    [NB_CORES],
   input  apu_cfg_pkg::data_t     operand_c_i    [NB_CORES],

   output logic                   ack_o          [NB_CORES],
   output logic                   result_valid_o [NB_CORES],
   output apu_cfg_pkg::data_t     result_o       [NB_CORES]
);

   import apu_cfg_pkg::*;
   import apu_op_pkg::*;

   localparam int TAG_W = $clog2(NB_CORES);

   mult_req_t        mult_req [NB_CORES];
   div_req_t         div_req  [NB_CORES];

   // Multiplier path
   logic             mult_valid;
   mult_req_t        mult_payload;
   logic [TAG_W-1:0] mult_tag;
   logic             mult_res_valid;
   logic [TAG_W-1:0] mult_res_tag;
   data_t            mult_res_data;
   logic             mult_ack       [NB_CORES];
   logic             mult_core_vld  [NB_CORES];
   data_t            mult_core_data [NB_CORES];

   // Divider path
   logic             div_valid;
   logic             div_ready;
   div_req_t         div_payload;
   logic [TAG_W-1:0] div_tag;
   logic             div_res_valid;
   logic [TAG_W-1:0] div_res_tag;
   data_t            div_res_data;
   logic             div_ack        [NB_CORES];
   logic             div_core_vld   [NB_CORES];
   data_t            div_core_data  [NB_CORES];

   // Per-core fields into both payload formats
   always_comb begin
      for (int i = 0; i < NB_CORES; i++) begin
         mult_req[i].op = mult_op_t'(op_i[i]);
         mult_req[i].a  = operand_a_i[i];
         mult_req[i].b  = operand_b_i[i];
         mult_req[i].c  = operand_c_i[i];
         div_req[i].op  = div_op_t'(op_i[i]);
         div_req[i].a   = operand_a_i[i];
         div_req[i].b   = operand_b_i[i];
      end
   end

   //////////////////////////////
   // Multiplier
   //////////////////////////////

   apu_arbiter #(
      .NB_CORES  (NB_CORES),
      .APU_TYPE  (APU_MULT),
      .payload_t (mult_req_t)
   ) u_mult_arb (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .req_i            (req_i),
      .type_i           (type_i),
      .payload_i        (mult_req),
      .ack_o            (mult_ack),
      .unit_valid_o     (mult_valid),
      .unit_ready_i     (1'b1),
      .unit_payload_o   (mult_payload),
      .unit_tag_o       (mult_tag),
      .unit_res_valid_i (mult_res_valid),
      .unit_res_tag_i   (mult_res_tag),
      .unit_res_data_i  (mult_res_data),
      .res_valid_o      (mult_core_vld),
      .res_data_o       (mult_core_data)
   );

   int_mult_unit #(
      .NB_CORES    (NB_CORES),
      .MULT_STAGES (MULT_STAGES)
   ) u_mult (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .valid_i     (mult_valid),
      .payload_i   (mult_payload),
      .tag_i       (mult_tag),
      .res_valid_o (mult_res_valid),
      .res_tag_o   (mult_res_tag),
      .res_data_o  (mult_res_data)
   );

   //////////////////////////////
   // Divider
   //////////////////////////////

   apu_arbiter #(
      .NB_CORES  (NB_CORES),
      .APU_TYPE  (APU_DIV),
      .payload_t (div_req_t)
   ) u_div_arb (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .req_i            (req_i),
      .type_i           (type_i),
      .payload_i        (div_req),
      .ack_o            (div_ack),
      .unit_valid_o     (div_valid),
      .unit_ready_i     (div_ready),
      .unit_payload_o   (div_payload),
      .unit_tag_o       (div_tag),
      .unit_res_valid_i (div_res_valid),
      .unit_res_tag_i   (div_res_tag),
      .unit_res_data_i  (div_res_data),
      .res_valid_o      (div_core_vld),
      .res_data_o       (div_core_data)
   );

   int_div_unit #(
      .NB_CORES (NB_CORES)
   ) u_div (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .valid_i     (div_valid),
      .ready_o     (div_ready),
      .payload_i   (div_payload),
      .tag_i       (div_tag),
      .res_valid_o (div_res_valid),
      .res_tag_o   (div_res_tag),
      .res_data_o  (div_res_data)
   );

   // Back toward the cores
   core_return_merge #(
      .NB_CORES (NB_CORES)
   ) u_merge (
      .mult_ack_i       (mult_ack),
      .mult_res_valid_i (mult_core_vld),
      .mult_res_data_i  (mult_core_data),
      .div_ack_i        (div_ack),
      .div_res_valid_i  (div_core_vld),
      .div_res_data_i   (div_core_data),
      .ack_o            (ack_o),
      .result_valid_o   (result_valid_o),
      .result_o         (result_o)
   );

endmodule

`default_nettype wire

//--- hw/core_return_merge.sv
// Per-core merge of acks and results coming from the multiplier and divider arbiters
`default_nettype none

module core_return_merge #(
   parameter int NB_CORES = apu_cfg_pkg::DEF_NB_CORES
) (
   // Multiplier arbiter side
   input  logic               mult_ack_i       [NB_CORES],
   input  logic               mult_res_valid_i [NB_CORES],
   input  apu_cfg_pkg::data_t mult_res_data_i  [NB_CORES],

   // Divider arbiter side
   input  logic               div_ack_i        [NB_CORES],
   input  logic               div_res_valid_i  [NB_CORES],
   input  apu_cfg_pkg::data_t div_res_data_i   [NB_CORES],

   // Toward the cores
   output logic               ack_o            [NB_CORES],
   output logic               result_valid_o   [NB_CORES],
   output apu_cfg_pkg::data_t result_o         [NB_CORES]
);

   // A core has one request in flight, so at most one side is active
   always_comb begin
      for (int i = 0; i < NB_CORES; i++) begin
         ack_o[i]          = mult_ack_i[i] || div_ack_i[i];
         result_valid_o[i] = mult_res_valid_i[i] || div_res_valid_i[i];
         if (mult_res_valid_i[i]) begin
            result_o[i] = mult_res_data_i[i];
         end else if (div_res_valid_i[i]) begin
            result_o[i] = div_res_data_i[i];
         end else begin
            // Quiet bus when nothing returns
            result_o[i] = '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/int_div_unit.sv
// Iterative restoring divider (DIV, DIVU, REM, REMU) with sign and zero handling
`default_nettype none

module int_div_unit #(
   parameter int  NB_CORES = apu_cfg_pkg::DEF_NB_CORES,
   localparam int TAG_W    = $clog2(NB_CORES)
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 valid_i,
   output logic                 ready_o,
   input  apu_op_pkg::div_req_t payload_i,
   input  logic [TAG_W-1:0]     tag_i,
   output logic                 res_valid_o,
   output logic [TAG_W-1:0]     res_tag_o,
   output apu_cfg_pkg::data_t   res_data_o
);

   import apu_cfg_pkg::*;
   import apu_op_pkg::*;

   localparam int CNT_W = $clog2(DATA_WIDTH);

   typedef enum logic [1:0] {
      S_IDLE,
      S_RUN,
      S_FIX
   } div_state_e;

   div_state_e         state_q;
   logic [CNT_W-1:0]   cnt_q;
   data_t              rem_q;
   data_t              quo_q;
   data_t              divisor_q;
   logic [TAG_W-1:0]   tag_q;
   logic               neg_quo_q;
   logic               neg_rem_q;
   logic               is_rem_q;

   logic               is_signed;
   data_t              abs_a;
   data_t              abs_b;
   logic [DATA_WIDTH:0] trial;
   data_t              quo_fix;
   data_t              rem_fix;

   assign ready_o   = (state_q == S_IDLE);
   assign res_tag_o = tag_q;

   // Operand conditioning on accept
   always_comb begin
      is_signed = (payload_i.op == OP_DIV) || (payload_i.op == OP_REM);
      abs_a = (is_signed && payload_i.a[DATA_WIDTH-1]) ? -payload_i.a : payload_i.a;
      abs_b = (is_signed && payload_i.b[DATA_WIDTH-1]) ? -payload_i.b : payload_i.b;
   end

   // One restoring step, MSB set means the subtraction went negative
   assign trial = {rem_q, quo_q[DATA_WIDTH-1]} - {1'b0, divisor_q};

   // A zero divisor leaves all ones and the dividend on its own
   assign quo_fix = neg_quo_q ? -quo_q : quo_q;
   assign rem_fix = neg_rem_q ? -rem_q : rem_q;

   //////////////////////////////
   // Control
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= S_IDLE;
         res_valid_o <= 1'b0;
      end else begin
         res_valid_o <= 1'b0;
         case (state_q)
            S_IDLE: begin
               if (valid_i) begin
                  state_q <= S_RUN;
               end
            end
            S_RUN: begin
               if (cnt_q == CNT_W'(DATA_WIDTH - 1)) begin
                  state_q <= S_FIX;
               end
            end
            S_FIX: begin
               state_q     <= S_IDLE;
               res_valid_o <= 1'b1;
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   //////////////////////////////
   // Datapath
   //////////////////////////////

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && valid_i) begin
         quo_q     <= abs_a;
         rem_q     <= '0;
         divisor_q <= abs_b;
         cnt_q     <= '0;
         tag_q     <= tag_i;
         is_rem_q  <= (payload_i.op == OP_REM) || (payload_i.op == OP_REMU);
         // Quotient sign flips only for a real divisor
         neg_quo_q <= is_signed && (payload_i.a[DATA_WIDTH-1] ^ payload_i.b[DATA_WIDTH-1])
                      && (payload_i.b != '0);
         neg_rem_q <= is_signed && payload_i.a[DATA_WIDTH-1];
      end else if (state_q == S_RUN) begin
         cnt_q <= cnt_q + 1'b1;
         if (!trial[DATA_WIDTH]) begin
            rem_q <= trial[DATA_WIDTH-1:0];
            quo_q <= {quo_q[DATA_WIDTH-2:0], 1'b1};
         end else begin
            rem_q <= {rem_q[DATA_WIDTH-2:0], quo_q[DATA_WIDTH-1]};
            quo_q <= {quo_q[DATA_WIDTH-2:0], 1'b0};
         end
      end else if (state_q == S_FIX) begin
         res_data_o <= is_rem_q ? rem_fix : quo_fix;
      end
   end

endmodule

`default_nettype wire

//--- hw/int_mult_unit.sv
// Pipelined integer multiplier (MUL, MULH, MULHU, MAC) with valid and tag pipeline
`default_nettype none

module int_mult_unit #(
   parameter int  NB_CORES    = apu_cfg_pkg::DEF_NB_CORES,
   parameter int  MULT_STAGES = apu_cfg_pkg::DEF_MULT_STAGES,
   localparam int TAG_W       = $clog2(NB_CORES)
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  valid_i,
   input  apu_op_pkg::mult_req_t payload_i,
   input  logic [TAG_W-1:0]      tag_i,
   output logic                  res_valid_o,
   output logic [TAG_W-1:0]      res_tag_o,
   output apu_cfg_pkg::data_t    res_data_o
);

   import apu_cfg_pkg::*;
   import apu_op_pkg::*;

   logic signed [2*DATA_WIDTH-1:0] prod_s;
   logic [2*DATA_WIDTH-1:0]        prod_u;
   data_t                          result_d;

   logic [MULT_STAGES-1:0] valid_q;
   logic [TAG_W-1:0]       tag_q  [MULT_STAGES];
   data_t                  data_q [MULT_STAGES];

   // Full width products, low word is the same for both
   always_comb begin
      prod_s = $signed(payload_i.a) * $signed(payload_i.b);
      prod_u = {{DATA_WIDTH{1'b0}}, payload_i.a} * {{DATA_WIDTH{1'b0}}, payload_i.b};
      case (payload_i.op)
         OP_MUL:   result_d = prod_u[DATA_WIDTH-1:0];
         OP_MULH:  result_d = prod_s[2*DATA_WIDTH-1:DATA_WIDTH];
         OP_MULHU: result_d = prod_u[2*DATA_WIDTH-1:DATA_WIDTH];
         default:  result_d = prod_u[DATA_WIDTH-1:0] + payload_i.c;
      endcase
   end

   // Valid chain
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else begin
         valid_q[0] <= valid_i;
         for (int s = 1; s < MULT_STAGES; s++) begin
            valid_q[s] <= valid_q[s-1];
         end
      end
   end

   // Result and tag move along with their valid bit
   always_ff @(posedge clk_i) begin
      data_q[0] <= result_d;
      tag_q[0]  <= tag_i;
      for (int s = 1; s < MULT_STAGES; s++) begin
         data_q[s] <= data_q[s-1];
         tag_q[s]  <= tag_q[s-1];
      end
   end

   assign res_valid_o = valid_q[MULT_STAGES-1];
   assign res_tag_o   = tag_q[MULT_STAGES-1];
   assign res_data_o  = data_q[MULT_STAGES-1];

endmodule

`default_nettype wire

//--- hw/apu_arbiter.sv
// Per-type round-robin arbiter with tag issue toward its unit and tagged result return
`default_nettype none

module apu_arbiter #(
   parameter int                    NB_CORES = apu_cfg_pkg::DEF_NB_CORES,
   parameter apu_cfg_pkg::apu_type_t APU_TYPE = apu_cfg_pkg::APU_MULT,
   parameter type                   payload_t = logic,
   localparam int                   TAG_W    = $clog2(NB_CORES)
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   // Core side requests
   input  logic                   req_i      [NB_CORES],
   input  apu_cfg_pkg::apu_type_t type_i     [NB_CORES],
   input  payload_t               payload_i  [NB_CORES],
   output logic                   ack_o      [NB_CORES],

   // Issue toward the unit
   output logic                   unit_valid_o,
   input  logic                   unit_ready_i,
   output payload_t               unit_payload_o,
   output logic [TAG_W-1:0]       unit_tag_o,

   // Result coming back from the unit
   input  logic                   unit_res_valid_i,
   input  logic [TAG_W-1:0]       unit_res_tag_i,
   input  apu_cfg_pkg::data_t     unit_res_data_i,

   // Per-core result
   output logic                   res_valid_o [NB_CORES],
   output apu_cfg_pkg::data_t     res_data_o  [NB_CORES]
);

   logic             req_match [NB_CORES];
   logic [TAG_W-1:0] ptr_q;
   logic [TAG_W-1:0] sel_idx;
   logic             sel_found;

   // Only requests of this unit's type take part
   always_comb begin
      for (int i = 0; i < NB_CORES; i++) begin
         req_match[i] = req_i[i] && (type_i[i] == APU_TYPE);
      end
   end

   //////////////////////////////
   // Round robin selection
   //////////////////////////////

   // Scan starting at the pointer, wrap past the last core
   always_comb begin
      int idx;
      sel_found = 1'b0;
      sel_idx   = '0;
      for (int k = 0; k < NB_CORES; k++) begin
         idx = int'(ptr_q) + k;
         if (idx >= NB_CORES) begin
            idx = idx - NB_CORES;
         end
         if (!sel_found && req_match[idx]) begin
            sel_found = 1'b1;
            sel_idx   = TAG_W'(idx);
         end
      end
   end

   // Grant only when the unit can take it
   assign unit_valid_o   = sel_found && unit_ready_i;
   assign unit_payload_o = payload_i[sel_idx];
   assign unit_tag_o     = sel_idx;

   always_comb begin
      for (int i = 0; i < NB_CORES; i++) begin
         ack_o[i] = unit_valid_o && (sel_idx == TAG_W'(i));
      end
   end

   // Next search starts just after the core that got through
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ptr_q <= '0;
      end else if (unit_valid_o) begin
         if (sel_idx == TAG_W'(NB_CORES - 1)) begin
            ptr_q <= '0;
         end else begin
            ptr_q <= sel_idx + 1'b1;
         end
      end
   end

   //////////////////////////////
   // Result return
   //////////////////////////////

   // Tag picks the core, data fans out to all
   always_comb begin
      for (int i = 0; i < NB_CORES; i++) begin
         res_valid_o[i] = unit_res_valid_i && (unit_res_tag_i == TAG_W'(i));
         res_data_o[i]  = unit_res_data_i;
      end
   end

endmodule

`default_nettype wire

//--- hw/apu_op_pkg.sv
// Operation encodings of both units and their request payload structs
`default_nettype none

package apu_op_pkg;

   // Raw operation field as it leaves the core
   typedef logic [1:0] op_t;

   // Multiplier operations
   typedef enum logic [1:0] {
      OP_MUL   = 2'd0,
      OP_MULH  = 2'd1,
      OP_MULHU = 2'd2,
      OP_MAC   = 2'd3
   } mult_op_t;

   // Divider operations
   typedef enum logic [1:0] {
      OP_DIV  = 2'd0,
      OP_DIVU = 2'd1,
      OP_REM  = 2'd2,
      OP_REMU = 2'd3
   } div_op_t;

   // Multiplier request, c only matters for MAC
   typedef struct packed {
      mult_op_t           op;
      apu_cfg_pkg::data_t a;
      apu_cfg_pkg::data_t b;
      apu_cfg_pkg::data_t c;
   } mult_req_t;

   // Divider request, a is the dividend
   typedef struct packed {
      div_op_t            op;
      apu_cfg_pkg::data_t a;
      apu_cfg_pkg::data_t b;
   } div_req_t;

endpackage

`default_nettype wire

//--- hw/apu_cfg_pkg.sv
// Cluster structure: data width, unit type codes, default core count and pipeline depth
`default_nettype none

package apu_cfg_pkg;

   //////////////////////////////
   // Datapath
   //////////////////////////////

   // Operand and result width of every shared unit
   localparam int DATA_WIDTH = 32;

   typedef logic [DATA_WIDTH-1:0] data_t;

   //////////////////////////////
   // Unit types
   //////////////////////////////

   // Type code a core sends along with its request
   typedef enum logic {
      APU_MULT = 1'b0,
      APU_DIV  = 1'b1
   } apu_type_t;

   //////////////////////////////
   // Cluster defaults
   //////////////////////////////

   // Cores sharing the units, 2 to 8
   localparam int DEF_NB_CORES = 4;

   // Multiplier register stages, 1 to 4
   localparam int DEF_MULT_STAGES = 2;

endpackage

`default_nettype wire
